// ==== Bender.yml ====
package:
  name: instr_fetch

sources:
  - files:
      - design/fetchPkg.sv
      - design/fetchPcCounter.sv
      - design/fetchAlignFsm.sv
      - design/fetchWordBuffer.sv
      - design/instrAssembler.sv
      - design/instrFetchTop.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/instrFetchTb.sv

// ==== design/fetchAlignFsm.sv ====
// Aligner FSM tracking split 32-bit instructions and decode bubbles

`timescale 1ns/1ps

module fetchAlignFsm (
  input  logic               clk,
  input  logic               arstN,
  input  logic               stall,
  input  logic               redirect,
  input  logic               splitStart,
  output fetchPkg::alignCtlS alignCtl
);

  import fetchPkg::*;

  alignStateE state;
  alignStateE stateNext;

  // High in the unstalled cycle that reads the low half of a split instruction
  logic firstSplit;

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  // Only a cycle that actually advances may start a split
  assign firstSplit = (state == stAligned) && splitStart && !stall && !redirect;

  always_comb begin
    stateNext = state;
    unique case (state)
      stAligned: begin
        // The low half sits in the top parcel of this word
        if (firstSplit) begin
          stateNext = stSplitHigh;
        end
      end
      stSplitHigh: begin
        // One unstalled cycle brings in the next word
        if (!stall) begin
          stateNext = stAligned;
        end
      end
      default: begin
        stateNext = stAligned;
      end
    endcase
    // A redirect drops any half-built instruction
    if (redirect) begin
      stateNext = stAligned;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= stAligned;
    end else begin
      state <= stateNext;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  // The buffer uses splitHigh to address the next word
  assign alignCtl.splitHigh = (state == stSplitHigh);

  // Decode takes a NOP after a redirect, even a stalled one, and while
  // the low half of a split is parked in the assembler
  assign alignCtl.bubble = redirect || firstSplit;

endmodule

// ==== design/fetchPcCounter.sv ====
// Program counter with redirect load and 2 or 4 byte step

`timescale 1ns/1ps

module fetchPcCounter (
  input  logic           clk,
  input  logic           arstN,
  input  logic           stall,
  input  logic           redirect,
  input  fetchPkg::addrT redirectPc,
  input  logic           pcStep,
  input  logic           stepCompressed,
  output fetchPkg::addrT fetchPc
);

  import fetchPkg::*;

  // Byte distance to the next instruction
  addrT stepSize;

  // The next parcel follows 2 bytes on for a compressed instruction
  // and 4 bytes on for a full one
  assign stepSize = stepCompressed ? addrT'(2) : addrT'(4);

  ////////////////////////////////////////////////////////////////////////////
  // Counter register
  ////////////////////////////////////////////////////////////////////////////

  // Redirect wins over stall so a branch target is never lost
  // While the first half of a split instruction is fetched pcStep is low
  // and the counter keeps pointing at the start of that instruction
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      fetchPc <= ResetPc;
    end else if (redirect) begin
      fetchPc <= redirectPc;
    end else if (!stall && pcStep) begin
      fetchPc <= fetchPc + stepSize;
    end
  end

endmodule

// ==== design/fetchPkg.sv ====
// Fetch widths, aligner state enum, buffer/control/decode structs, NOP and reset PC constants

package fetchPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths that carry a meaning
  ////////////////////////////////////////////////////////////////////////////

  // Byte address as seen by the program counter and the memory port
  typedef logic [31:0] addrT;

  // One instruction memory word
  typedef logic [31:0] wordT;

  // One instruction parcel, the unit that pc[1] selects
  typedef logic [15:0] halfT;

  // Instruction handed to decode, compressed parcels sit zero-extended
  typedef logic [31:0] instrT;

  // Aligner states
  // stSplitHigh means the low half of a split instruction is saved and the
  // next word is being read for its high half
  typedef enum logic {
    stAligned   = 1'b0,
    stSplitHigh = 1'b1
  } alignStateE;

  ////////////////////////////////////////////////////////////////////////////
  // Grouped signals
  ////////////////////////////////////////////////////////////////////////////

  // Last word read from memory together with the word address it came from
  typedef struct packed {
    wordT data;
    addrT adr;
    logic valid;
  } bufEntryS;

  // Control from the aligner FSM to the buffer and the assembler
  typedef struct packed {
    logic splitHigh;
    logic bubble;
  } alignCtlS;

  // Contents of the decode register
  typedef struct packed {
    instrT instr;
    logic  compressed;
  } decodeS;

  // addi x0, x0, 0
  localparam instrT NopInstr = 32'h0000_0013;

  // First fetch address after reset
  localparam addrT ResetPc = 32'h0000_0000;

endpackage

// ==== design/fetchWordBuffer.sv ====
// One-entry buffer of the last memory word, memory address and read request

`timescale 1ns/1ps

module fetchWordBuffer (
  input  logic               clk,
  input  logic               arstN,
  input  logic               stall,
  input  logic               redirect,
  input  fetchPkg::addrT     fetchPc,
  input  fetchPkg::alignCtlS alignCtl,
  input  fetchPkg::wordT     memData,
  output fetchPkg::addrT     memAdr,
  output logic               memRead,
  output fetchPkg::wordT     fetchWord
);

  import fetchPkg::*;

  // Buffered payload and its valid flag
  wordT     entryData;
  addrT     entryAdr;
  logic     entryValid;
  bufEntryS entry;

  // Word index of the fetch, one further when the high half of a split is due
  logic [29:0] wordIdx;

  ////////////////////////////////////////////////////////////////////////////
  // Address and hit test
  ////////////////////////////////////////////////////////////////////////////

  assign wordIdx = fetchPc[31:2] + 30'(alignCtl.splitHigh);
  assign memAdr  = {wordIdx, 2'b00};

  assign entry = '{data: entryData, adr: entryAdr, valid: entryValid};

  // Reading memory again is skipped when the wanted word is already held
  assign memRead = !(entry.valid && (entry.adr == memAdr));

  // Memory answers in the same cycle, so a miss forwards memData directly
  assign fetchWord = memRead ? memData : entry.data;

  ////////////////////////////////////////////////////////////////////////////
  // Buffer registers
  ////////////////////////////////////////////////////////////////////////////

  // A redirect empties the entry so the target is always read from memory
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      entryValid <= 1'b0;
    end else if (redirect) begin
      entryValid <= 1'b0;
    end else if (memRead && !stall) begin
      entryValid <= 1'b1;
    end
  end

  // Word and word address of every read that the pipeline takes
  always_ff @(posedge clk) begin
    if (memRead && !stall) begin
      entryData <= memData;
      entryAdr  <= memAdr;
    end
  end

endmodule

// ==== design/instrAssembler.sv ====
// Halfword select, compressed detect, saved split half and decode register

`timescale 1ns/1ps

module instrAssembler (
  input  logic               clk,
  input  logic               arstN,
  input  logic               stall,
  input  fetchPkg::addrT     fetchPc,
  input  fetchPkg::wordT     fetchWord,
  input  fetchPkg::alignCtlS alignCtl,
  output logic               splitStart,
  output logic               pcStep,
  output logic               stepCompressed,
  output fetchPkg::decodeS   decode
);

  import fetchPkg::*;

  // Parcel that pc[1] points at in the current word
  halfT curHalf;

  // Low half of a split instruction, kept until the next word arrives
  halfT savedHalf;

  // Compressed opcodes have anything but 2'b11 in the low two bits
  logic curCompressed;

  // Instruction as it would enter decode without a bubble
  decodeS decodeNext;

  ////////////////////////////////////////////////////////////////////////////
  // Parcel selection
  ////////////////////////////////////////////////////////////////////////////

  assign curHalf       = fetchPc[1] ? fetchWord[31:16] : fetchWord[15:0];
  assign curCompressed = (curHalf[1:0] != 2'b11);

  // A full opcode in the top parcel runs over into the next word
  assign splitStart = !alignCtl.splitHigh && fetchPc[1] && !curCompressed;

  // The counter waits on the first half of a split and moves on otherwise
  assign pcStep = !splitStart;

  // The second half of a split always finishes a full instruction
  assign stepCompressed = !alignCtl.splitHigh && curCompressed;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction assembly
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    decodeNext.compressed = stepCompressed;
    if (alignCtl.splitHigh) begin
      // Upper 16 bits come from the bottom parcel of the new word
      decodeNext.instr = {fetchWord[15:0], savedHalf};
    end else if (curCompressed) begin
      decodeNext.instr = {16'h0000, curHalf};
    end else begin
      // Aligned full instruction, pc[1] is 0 here
      decodeNext.instr = fetchWord;
    end
  end

  // Keep the top parcel of the word that starts a split
  always_ff @(posedge clk) begin
    if (splitStart && !stall) begin
      savedHalf <= curHalf;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Decode register
  ////////////////////////////////////////////////////////////////////////////

  // Stall freezes decode unless a bubble arrives
  // The FSM only raises bubble under stall for a redirect
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      decode <= '{instr: NopInstr, compressed: 1'b0};
    end else if (alignCtl.bubble) begin
      decode <= '{instr: NopInstr, compressed: 1'b0};
    end else if (!stall) begin
      decode <= decodeNext;
    end
  end

endmodule

// ==== design/instrFetchTop.sv ====
// Fetch top level joining PC counter, aligner FSM, word buffer and assembler

`timescale 1ns/1ps

module instrFetchTop (
  input  logic             clk,
  input  logic             arstN,
  input  logic             stall,
  input  logic             redirect,
  input  fetchPkg::addrT   redirectPc,
  input  fetchPkg::wordT   memData,
  output fetchPkg::addrT   memAdr,
  output logic             memRead,
  output fetchPkg::addrT   fetchPc,
  output fetchPkg::decodeS decode
);

  import fetchPkg::*;

  // Control from the FSM to buffer and assembler
  alignCtlS alignCtl;

  // Word seen by the assembler this cycle
  wordT fetchWord;

  // Step requests from the assembler
  logic splitStart;
  logic pcStep;
  logic stepCompressed;

  fetchPcCounter pcCounter (
    .clk            (clk),
    .arstN          (arstN),
    .stall          (stall),
    .redirect       (redirect),
    .redirectPc     (redirectPc),
    .pcStep         (pcStep),
    .stepCompressed (stepCompressed),
    .fetchPc        (fetchPc)
  );

  fetchAlignFsm alignFsm (
    .clk        (clk),
    .arstN      (arstN),
    .stall      (stall),
    .redirect   (redirect),
    .splitStart (splitStart),
    .alignCtl   (alignCtl)
  );

  fetchWordBuffer wordBuffer (
    .clk       (clk),
    .arstN     (arstN),
    .stall     (stall),
    .redirect  (redirect),
    .fetchPc   (fetchPc),
    .alignCtl  (alignCtl),
    .memData   (memData),
    .memAdr    (memAdr),
    .memRead   (memRead),
    .fetchWord (fetchWord)
  );

  instrAssembler assembler (
    .clk            (clk),
    .arstN          (arstN),
    .stall          (stall),
    .fetchPc        (fetchPc),
    .fetchWord      (fetchWord),
    .alignCtl       (alignCtl),
    .splitStart     (splitStart),
    .pcStep         (pcStep),
    .stepCompressed (stepCompressed),
    .decode         (decode)
  );

endmodule

// ==== sim/fetchTbProgram.svh ====
// Program memory image, filler generation and the directed per-cycle test table
`ifndef FETCH_TB_PROGRAM_SVH
`define FETCH_TB_PROGRAM_SVH

  // 64 words cover every address that the table reaches
  wordT progMem [0:63];

  ////////////////////////////////////////////////////////////////////////////
  // Program image
  ////////////////////////////////////////////////////////////////////////////

  task automatic loadProgram();
    wordT filler;
    // Odd filler words from word 7 up hold two compressed parcels and even
    // words hold a full opcode in both parcels, so a jump to an even word
    // plus 2 always starts a split
    for (int i = 7; i < 64; i++) begin
      filler = $urandom() ^ (32'(i) * 32'h9e37_79b9);
      if (i % 2 == 1) begin
        filler[1:0]   = 2'b01;
        filler[17:16] = 2'b10;
      end else begin
        filler[1:0]   = 2'b11;
        filler[17:16] = 2'b11;
      end
      progMem[i] = filler;
    end
    // Two aligned full instructions
    progMem[0] = 32'h0050_0093;
    progMem[1] = 32'h00a0_0113;
    // Pair of c.li parcels
    progMem[2] = 32'h4585_4505;
    // c.nop below and the low half of 0x00c00193 above
    progMem[3] = 32'h0193_0001;
    // High half of the split instruction below and c.jr above
    progMem[4] = 32'h8082_00c0;
    progMem[5] = 32'h0020_8233;
    progMem[6] = 32'h4020_8233;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed table with one row per clock cycle
  ////////////////////////////////////////////////////////////////////////////

  task automatic buildTable();
    //     name                stall redir target     check
    addRow("aligned0",         1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("aligned4",         1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("compLow",          1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("compHighHit",      1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("compNop",          1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("splitFirst",       1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("splitSecond",      1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("compAfterSplit",   1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("stallHold",        1'b1, 1'b0, 32'h0000, 1'b1);
    addRow("stallHold2",       1'b1, 1'b0, 32'h0000, 1'b1);
    addRow("aligned14",        1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("aligned18",        1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("fillerComp",       1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("fillerCompHit",    1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("fillerFull",       1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("redirectSplit",    1'b0, 1'b1, 32'h000e, 1'b1);
    addRow("splitAfterRedir",  1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("splitStalled",     1'b1, 1'b0, 32'h0000, 1'b1);
    addRow("splitResume",      1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("stallRedirect",    1'b1, 1'b1, 32'h0008, 1'b1);
    addRow("stallAfterRedir",  1'b1, 1'b0, 32'h0000, 1'b1);
    addRow("compAtTarget",     1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("compHighHit2",     1'b0, 1'b0, 32'h0000, 1'b1);
    // The target lies in the word that this cycle buffers
    addRow("redirectSameWord", 1'b0, 1'b1, 32'h000c, 1'b1);
    addRow("compNopTarget",    1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("splitBeforeRedir", 1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("redirectFiller",   1'b0, 1'b1, 32'h0022, 1'b1);
    addRow("fillerSplit",      1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("fillerSplit2",     1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("fillerCompHigh",   1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("fillerFull2",      1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("redirectE",        1'b0, 1'b1, 32'h000e, 1'b1);
    addRow("stallAtSplit",     1'b1, 1'b0, 32'h0000, 1'b1);
    addRow("splitFirst3",      1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("splitSecond3",     1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("tailComp",         1'b0, 1'b0, 32'h0000, 1'b1);
    addRow("tailFull",         1'b0, 1'b0, 32'h0000, 1'b1);
  endtask

`endif

// ==== sim/instrFetchTb.sv ====
// Fetch aligner testbench with memory model, reference walker, compare tasks and timeout

`timescale 1ns/1ps

module instrFetchTb;

  import fetchPkg::*;

  logic   clk;
  logic   arstN;
  logic   stall;
  logic   redirect;
  addrT   redirectPc;
  wordT   memData;
  addrT   memAdr;
  logic   memRead;
  addrT   fetchPc;
  decodeS decode;

  // Table columns that buildTable fills
  string rowName[$];
  logic  rowStall[$];
  logic  rowRedirect[$];
  addrT  rowTarget[$];
  logic  rowCheck[$];

  // Reference walker state after the last applied row
  addrT   refPc;
  logic   refSplit;
  halfT   refSaved;
  logic   refBufValid;
  addrT   refBufAdr;
  decodeS refDecode;

  int          cycleCount = 0;
  int          cycleLimit = 0;
  int          testsPassed = 0;
  int          testsFailed = 0;
  int          rowErrors;
  int          seed;

  task automatic addRow(input string name, input logic rowSt, input logic rowRd,
                        input addrT target, input logic check);
    rowName.push_back(name);
    rowStall.push_back(rowSt);
    rowRedirect.push_back(rowRd);
    rowTarget.push_back(target);
    rowCheck.push_back(check);
  endtask

  `include "fetchTbProgram.svh"

  // Combinational memory that answers in the cycle of the address
  assign memData = progMem[memAdr[7:2]];

  instrFetchTop dut (
    .clk        (clk),
    .arstN      (arstN),
    .stall      (stall),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .memData    (memData),
    .memAdr     (memAdr),
    .memRead    (memRead),
    .fetchPc    (fetchPc),
    .decode     (decode)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Run limit grows with the table length
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("Timeout after %0d cycles, the table never finished", cycleCount);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference walker
  ////////////////////////////////////////////////////////////////////////////

  // Word holding the pc, or the word after it while a split waits
  function automatic addrT refMemAdr();
    return (refPc & ~32'h3) + (refSplit ? 32'd4 : 32'd0);
  endfunction

  function automatic logic refMemRead();
    return !(refBufValid && (refBufAdr == refMemAdr()));
  endfunction

  task automatic advanceReference(input logic st, input logic rd, input addrT target);
    addrT adr;
    wordT word;
    halfT half;
    logic isComp;
    adr    = refMemAdr();
    word   = progMem[adr[7:2]];
    half   = refPc[1] ? word[31:16] : word[15:0];
    isComp = (half[1:0] != 2'b11);
    if (rd) begin
      // Redirect beats stall and empties the buffer
      refPc       = target;
      refSplit    = 1'b0;
      refBufValid = 1'b0;
      refDecode   = '{instr: NopInstr, compressed: 1'b0};
    end else if (!st) begin
      if (refMemRead()) begin
        refBufValid = 1'b1;
        refBufAdr   = adr;
      end
      if (refSplit) begin
        refDecode = '{instr: {word[15:0], refSaved}, compressed: 1'b0};
        refPc     = refPc + 32'd4;
        refSplit  = 1'b0;
      end else if (refPc[1] && !isComp) begin
        refSaved  = half;
        refSplit  = 1'b1;
        refDecode = '{instr: NopInstr, compressed: 1'b0};
      end else if (isComp) begin
        refDecode = '{instr: {16'h0000, half}, compressed: 1'b1};
        refPc     = refPc + 32'd2;
      end else begin
        refDecode = '{instr: word, compressed: 1'b0};
        refPc     = refPc + 32'd4;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkDecode(input string name, input decodeS expected, input decodeS actual);
    if (actual !== expected) begin
      $display("[FAIL] %s decode expected %h/%0b actual %h/%0b", name,
               expected.instr, expected.compressed, actual.instr, actual.compressed);
      rowErrors++;
    end
  endtask

  task automatic checkAddr(input string name, input string what, input addrT expected,
                           input addrT actual);
    if (actual !== expected) begin
      $display("[FAIL] %s %s expected %h actual %h", name, what, expected, actual);
      rowErrors++;
    end
  endtask

  task automatic checkRead(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      if (expected) begin
        $display("%s: no memory read although the wanted word is not buffered", name);
      end else begin
        $display("%s: memory was read although the word was already buffered", name);
      end
      rowErrors++;
    end
  endtask

  task automatic reportTest(input string name);
    if (rowErrors == 0) begin
      testsPassed++;
      $display("%-18s ok", name);
    end else begin
      testsFailed++;
      $display("%-18s %0d mismatches", name, rowErrors);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    // Seed the generator once for the whole run
    seed       = 32'h408360c7;
    void'($urandom(seed));
    arstN      = 1'b0;
    stall      = 1'b0;
    redirect   = 1'b0;
    redirectPc = '0;
    loadProgram();
    buildTable();
    cycleLimit  = 3 * rowName.size() + 50;
    refPc       = ResetPc;
    refSplit    = 1'b0;
    refSaved    = '0;
    refBufValid = 1'b0;
    refBufAdr   = '0;
    refDecode   = '{instr: NopInstr, compressed: 1'b0};

    repeat (4) @(negedge clk);
    arstN = 1'b1;

    // Reset leaves an empty buffer, so the first fetch must read
    rowErrors = 0;
    checkAddr("reset", "fetchPc", ResetPc, fetchPc);
    checkDecode("reset", refDecode, decode);
    checkRead("reset", 1'b1, memRead);
    reportTest("reset");

    for (int r = 0; r < rowName.size(); r++) begin
      rowErrors  = 0;
      stall      = rowStall[r];
      redirect   = rowRedirect[r];
      redirectPc = rowTarget[r];
      #1;
      if (rowCheck[r]) begin
        checkAddr(rowName[r], "memAdr", refMemAdr(), memAdr);
        checkRead(rowName[r], refMemRead(), memRead);
      end
      advanceReference(rowStall[r], rowRedirect[r], rowTarget[r]);
      @(posedge clk);
      @(negedge clk);
      // Registered results of this row have settled since the rising edge
      if (rowCheck[r]) begin
        checkAddr(rowName[r], "fetchPc", refPc, fetchPc);
        checkDecode(rowName[r], refDecode, decode);
      end
      reportTest(rowName[r]);
    end

    $display("Summary: %0d passed, %0d failed", testsPassed, testsFailed);
    if (testsFailed == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+sim
design/fetchPkg.sv
design/fetchPcCounter.sv
design/fetchAlignFsm.sv
design/fetchWordBuffer.sv
design/instrAssembler.sv
design/instrFetchTop.sv
sim/instrFetchTb.sv
